// ==== logic/fetch_port.sv ====
`timescale 1ns/10ps
`include "loader_macros.svh"

module fetch_port (
    input  logic              sysclk,
    input  logic              sysrst,
    wb_bus_if.monitor         bus [`NUM_BANKS],
    output loader_pkg::word_t fetch_data,
    output logic              fetch_valid
);
    import loader_pkg::*;

    logic [`NUM_BANKS-1:0] read_hit;
    word_t                 bank_data [`NUM_BANKS];
    bank_idx_t             hit_idx;

    // Write acks are not for us
    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_watch
        assign read_hit[g]  = bus[g].ack && bus[g].stb && !bus[g].we;
        assign bank_data[g] = bus[g].dat_r;
    end

    // Only the selected bank can answer, so any match will do
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < `NUM_BANKS; i++) begin
            if (read_hit[i]) begin
                hit_idx = bank_idx_t'(i);
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= |read_hit;
        end
    end

    // Held until the next read answers
    always_ff @(posedge sysclk) begin
        if (|read_hit) begin
            fetch_data <= bank_data[hit_idx];
        end
    end

endmodule

// ==== logic/load_sequencer.sv ====
`timescale 1ns/10ps
`include "loader_macros.svh"

module load_sequencer (
    input  logic              sysclk,
    input  logic              sysrst,
    input  logic              load_en,
    input  loader_pkg::word_t word,
    input  logic              word_valid,
    input  logic              fetch_req,
    input  logic [5:0]        fetch_addr,
    output logic              loading,
    output logic [6:0]        word_count,
    output logic              fetch_ready,
    wb_bus_if.master          bus [`NUM_BANKS]
);
    import loader_pkg::*;

    localparam int TOTAL_WORDS = `NUM_BANKS * `BANK_DEPTH;
    localparam int IDX_W = $bits(bank_idx_t);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} state_t;

    state_t                state;
    logic [1:0]            load_sync;
    logic                  load_prev;
    logic                  load_rise;
    word_t                 hold_word;
    logic                  hold_full;
    logic                  count_full;
    logic                  write_start;
    logic                  write_drop;
    logic                  fetch_accept;
    bank_idx_t             cur_idx;
    bank_addr_t            cur_adr;
    logic                  cur_we;
    logic [`NUM_BANKS-1:0] ack_vec;
    logic                  bus_ack;

    assign loading    = load_sync[1];
    assign load_rise  = load_sync[1] & ~load_prev;
    assign count_full = (word_count >= 7'(TOTAL_WORDS));
    assign bus_ack    = ack_vec[cur_idx];

    assign write_start  = (state == ST_IDLE) && hold_full && loading && !count_full;
    assign write_drop   = (state == ST_IDLE) && hold_full && loading && count_full;
    assign fetch_accept = (state == ST_IDLE) && fetch_req && fetch_ready && !loading;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_sync   <= 2'b00;
            load_prev   <= 1'b0;
            state       <= ST_IDLE;
            word_count  <= '0;
            hold_full   <= 1'b0;
            fetch_ready <= 1'b0;
        end else begin
            load_sync <= {load_sync[0], load_en};
            load_prev <= load_sync[1];

            // Ready only once the bus is back to idle
            fetch_ready <= (state == ST_IDLE) && !loading && !fetch_accept;

            case (state)
                ST_IDLE: begin
                    if (write_start) begin
                        state <= ST_WRITE;
                    end else if (fetch_accept) begin
                        state <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (bus_ack) begin
                        state      <= ST_IDLE;
                        word_count <= word_count + 1'b1;
                    end
                end
                default: begin
                    if (bus_ack) begin
                        state <= ST_IDLE;
                    end
                end
            endcase

            if (write_start || write_drop || !loading) begin
                hold_full <= 1'b0;
            end
            if (word_valid && loading) begin
                hold_full <= 1'b1;
            end

            // New load session, count from zero again
            if (load_rise) begin
                word_count <= '0;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (word_valid && loading) begin
            hold_word <= word;
        end
    end

    // Address split: bank in the low bits, word in bank above
    always_ff @(posedge sysclk) begin
        if (write_start) begin
            cur_idx <= word_count[IDX_W-1:0];
            cur_adr <= word_count[5:IDX_W];
            cur_we  <= 1'b1;
        end else if (fetch_accept) begin
            cur_idx <= fetch_addr[IDX_W-1:0];
            cur_adr <= fetch_addr[5:IDX_W];
            cur_we  <= 1'b0;
        end
    end

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
        assign bus[g].cyc   = (state != ST_IDLE) && (cur_idx == bank_idx_t'(g));
        assign bus[g].stb   = (state != ST_IDLE) && (cur_idx == bank_idx_t'(g));
        assign bus[g].we    = cur_we;
        assign bus[g].adr   = cur_adr;
        assign bus[g].dat_w = hold_word;
        assign ack_vec[g]   = bus[g].ack;
    end

endmodule

// ==== logic/loader_macros.svh ====
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// Width of one instruction word
`define WORD_WIDTH 16

// Interleaved banks, consecutive word addresses go to consecutive banks
`define NUM_BANKS 4

// Words held by each bank
`define BANK_DEPTH 16

// Sysclk cycles per serial bit, kept short for simulation
`define BAUD_DIV 16

`endif

// ==== logic/loader_pkg.sv ====
`include "loader_macros.svh"

package loader_pkg;

    // One instruction word
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Bank number, the low bits of a word address
    typedef logic [$clog2(`NUM_BANKS)-1:0] bank_idx_t;

    // Word index inside one bank, the high bits of a word address
    typedef logic [$clog2(`BANK_DEPTH)-1:0] bank_addr_t;

endpackage

// ==== logic/mem_bank.sv ====
`timescale 1ns/10ps
`include "loader_macros.svh"

module mem_bank (
    input  logic     sysclk,
    input  logic     sysrst,
    wb_bus_if.slave  bus
);
    import loader_pkg::*;

    word_t mem [`BANK_DEPTH];
    logic  access;

    // A fresh strobe, the ack low check keeps it to one ack per cycle
    assign access = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge sysclk) begin
        if (access && bus.we) begin
            mem[bus.adr] <= bus.dat_w;
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge sysclk) begin
        if (access) begin
            bus.dat_r <= mem[bus.adr];
        end
    end

endmodule

// ==== logic/program_loader.sv ====
`timescale 1ns/10ps
`include "loader_macros.svh"

module program_loader (
    input  logic              sysclk,
    input  logic              sysrst,
    input  logic              rx,
    input  logic              load_en,
    input  logic              fetch_req,
    input  logic [5:0]        fetch_addr,
    output logic              fetch_ready,
    output loader_pkg::word_t fetch_data,
    output logic              fetch_valid,
    output logic [6:0]        word_count
);
    import loader_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    word_t      asm_word;
    logic       asm_word_valid;
    logic       loading;

    // One bus per bank
    wb_bus_if bank_bus [`NUM_BANKS] ();

    uart_rx uart_rx_inst (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .byte_data  (rx_byte),
        .byte_valid (rx_byte_valid)
    );

    word_assembler word_assembler_inst (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .byte_data  (rx_byte),
        .byte_valid (rx_byte_valid),
        .loading    (loading),
        .word       (asm_word),
        .word_valid (asm_word_valid)
    );

    load_sequencer load_sequencer_inst (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .load_en     (load_en),
        .word        (asm_word),
        .word_valid  (asm_word_valid),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .loading     (loading),
        .word_count  (word_count),
        .fetch_ready (fetch_ready),
        .bus         (bank_bus)
    );

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_mem
        mem_bank mem_bank_inst (
            .sysclk (sysclk),
            .sysrst (sysrst),
            .bus    (bank_bus[g])
        );
    end

    fetch_port fetch_port_inst (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .bus         (bank_bus),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid)
    );

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/10ps
`include "loader_macros.svh"

module uart_rx (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    // Sync and edge detect already take three cycles of the half bit
    localparam int HALF_WAIT = `BAUD_DIV / 2 - 3;
    localparam int CNT_W = $clog2(`BAUD_DIV);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic             rx_prev;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift;
    logic             rx_fall;
    logic             bit_tick;

    assign rx_fall  = rx_prev & ~rx_sync[1];
    assign bit_tick = (baud_cnt == CNT_W'(`BAUD_DIV - 1));
    assign byte_data = shift;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= RX_IDLE;
            rx_sync    <= 2'b11;
            rx_prev    <= 1'b1;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            rx_prev    <= rx_sync[1];
            byte_valid <= 1'b0;
            baud_cnt   <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rx_fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Mid start bit, a high line here was only a glitch
                    if (baud_cnt == CNT_W'(HALF_WAIT)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    // Stop bit must be high or the frame is thrown away
                    if (bit_tick) begin
                        state      <= RX_IDLE;
                        byte_valid <= rx_sync[1];
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge sysclk) begin
        if (state == RX_DATA && bit_tick) begin
            shift <= {rx_sync[1], shift[7:1]};
        end
    end

endmodule

// ==== logic/wb_bus_if.sv ====
`timescale 1ns/10ps

interface wb_bus_if;
    import loader_pkg::*;

    logic       cyc;
    logic       stb;
    logic       we;
    bank_addr_t adr;
    word_t      dat_w;
    word_t      dat_r;
    logic       ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

    // Observer on the bank side, used by the fetch path
    // we is needed to tell read acks from write acks
    modport monitor (
        input stb, we, dat_r, ack
    );

endinterface

// ==== logic/word_assembler.sv ====
`timescale 1ns/10ps

module word_assembler (
    input  logic              sysclk,
    input  logic              sysrst,
    input  logic [7:0]        byte_data,
    input  logic              byte_valid,
    input  logic              loading,
    output loader_pkg::word_t word,
    output logic              word_valid
);
    import loader_pkg::*;

    logic [7:0] low_byte;
    // High when the low byte of the pair is already held
    logic       have_low;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            have_low   <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (!loading) begin
                have_low <= 1'b0;
            end else if (byte_valid) begin
                have_low   <= ~have_low;
                word_valid <= have_low;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (loading && byte_valid) begin
            if (have_low) begin
                word <= word_t'({byte_data, low_byte});
            end else begin
                low_byte <= byte_data;
            end
        end
    end

endmodule

// ==== program_loader.f ====
+incdir+logic
logic/loader_pkg.sv
logic/wb_bus_if.sv
logic/uart_rx.sv
logic/word_assembler.sv
logic/load_sequencer.sv
logic/mem_bank.sv
logic/fetch_port.sv
logic/program_loader.sv
verification/tb_clock.sv
verification/program_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module program_loader_tb \
    -f program_loader.f \
    -o sim_program_loader

./obj_dir/sim_program_loader | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: simulation reported failure"
    exit 1
fi
echo "run_sim: simulation finished without failure"

// ==== verification/program_loader_tb.sv ====
`timescale 1ns/10ps
`include "loader_macros.svh"

module program_loader_tb;
    import loader_pkg::*;

    localparam int N_TESTS = 6;
    localparam int MAX_ITEMS = 24;
    localparam int K_LOAD = 0;
    localparam int K_FETCH = 1;
    localparam int K_BUSY = 2;
    localparam int READY_WAIT = 20;
    localparam int FETCH_WAIT = 20;
    localparam int COUNT_WAIT = 10 * `BAUD_DIV;
    localparam word_t IMAGE_A [12] = '{16'h3a01, 16'hc4e2, 16'h17b3, 16'h8f04, 16'h6d25,
                                       16'h02a6, 16'hbe57, 16'h7198, 16'h4c09, 16'hd3fa,
                                       16'h90cb, 16'h25dc};
    localparam word_t IMAGE_B [5] = '{16'hf00d, 16'h1357, 16'h2468, 16'hace1, 16'h0bd2};

    logic       sysclk;
    logic       sysrst;
    logic       rx;
    logic       load_en;
    logic       fetch_req;
    logic [5:0] fetch_addr;
    logic       fetch_ready;
    word_t      fetch_data;
    logic       fetch_valid;
    logic [6:0] word_count;

    // Stimulus table with one row per test
    string t_name   [N_TESTS];
    int    t_kind   [N_TESTS];
    bit    t_bad    [N_TESTS];
    int    t_nwords [N_TESTS];
    word_t t_image  [N_TESTS][MAX_ITEMS];
    int    t_nfetch [N_TESTS];
    int    t_faddr  [N_TESTS][MAX_ITEMS];

    // Expected memory contents where word n lands at address n
    word_t model [64];
    int    errors = 0;
    int    failed_tests = 0;
    int    limit_cycles = 0;
    logic [31:0] rng;

    tb_clock clock_inst (
        .sysclk (sysclk)
    );

    program_loader program_loader_inst (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .rx          (rx),
        .load_en     (load_en),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .word_count  (word_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic build_table();
        t_name = '{"load twelve", "fetch timing", "reload", "fetch while loading",
                   "random image", "bad frame"};
        t_kind = '{K_LOAD, K_FETCH, K_LOAD, K_BUSY, K_LOAD, K_LOAD};
        t_bad = '{0, 0, 0, 0, 0, 1};
        t_nwords = '{12, 0, 5, 0, 20, 1};
        t_nfetch = '{12, 3, 12, 1, 16, 2};
        for (int k = 0; k < 12; k++) begin
            t_image[0][k] = IMAGE_A[k];
            t_faddr[0][k] = k;
            t_faddr[2][k] = k;
        end
        for (int k = 0; k < 5; k++) begin
            t_image[2][k] = IMAGE_B[k];
        end
        t_faddr[1][0] = 9;
        t_faddr[1][1] = 2;
        t_faddr[1][2] = 7;
        t_faddr[3][0] = 6;
        rng = 32'd27;
        for (int k = 0; k < 20; k++) begin
            rng = xorshift(rng);
            t_image[4][k] = rng[15:0];
        end
        for (int k = 0; k < 16; k++) begin
            rng = xorshift(rng);
            t_faddr[4][k] = int'(rng % 32'd20);
        end
        t_image[5][0] = 16'h5ac3;
        t_faddr[5][0] = 0;
        t_faddr[5][1] = 1;
    endtask

    // 8N1 frame with one extra idle bit after a broken stop bit
    task automatic send_byte(input logic [7:0] b, input logic stop_level);
        @(negedge sysclk);
        rx = 1'b0;
        repeat (`BAUD_DIV) @(negedge sysclk);
        for (int k = 0; k < 8; k++) begin
            rx = b[k];
            repeat (`BAUD_DIV) @(negedge sysclk);
        end
        rx = stop_level;
        repeat (`BAUD_DIV) @(negedge sysclk);
        if (!stop_level) begin
            rx = 1'b1;
            repeat (`BAUD_DIV) @(negedge sysclk);
        end
    endtask

    task automatic send_word(input word_t w);
        send_byte(w[7:0], 1'b1);
        send_byte(w[15:8], 1'b1);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!fetch_ready && cycles < READY_WAIT) begin
            @(negedge sysclk);
            cycles++;
        end
        if (!fetch_ready) begin
            $display("timeout at %0t: fetch_ready never came back", $time);
            errors++;
        end
    endtask

    task automatic wait_count(input int target);
        int cycles;
        cycles = 0;
        while (int'(word_count) != target && cycles < COUNT_WAIT) begin
            @(negedge sysclk);
            cycles++;
        end
        if (int'(word_count) != target) begin
            $display("timeout at %0t: word_count stuck at %0d, waiting for %0d",
                     $time, word_count, target);
            errors++;
        end
    endtask

    // Synchronizer plus edge detect clear the count within four cycles
    task automatic start_load();
        @(negedge sysclk);
        load_en = 1'b1;
        repeat (4) @(negedge sysclk);
        check_eq(32'(word_count), 0, "word_count after load start");
    endtask

    task automatic stop_load();
        @(negedge sysclk);
        load_en = 1'b0;
        wait_ready();
    endtask

    task automatic do_fetch(input int addr);
        int lat;
        wait_ready();
        @(negedge sysclk);
        fetch_req = 1'b1;
        fetch_addr = 6'(addr);
        @(negedge sysclk);
        fetch_req = 1'b0;
        lat = 1;
        check_eq(32'(fetch_ready), 0, "fetch_ready after accepted request");
        while (!fetch_valid && lat < FETCH_WAIT) begin
            @(negedge sysclk);
            lat++;
        end
        if (!fetch_valid) begin
            $display("timeout at %0t: no fetch_valid for address %0d", $time, addr);
            errors++;
        end else begin
            check_eq(32'(lat), 3, "fetch_valid latency");
            check_eq(32'(fetch_data), 32'(model[addr]), "fetch_data");
            @(negedge sysclk);
            check_eq(32'(fetch_valid), 0, "fetch_valid pulse width");
            check_eq(32'(fetch_ready), 1, "fetch_ready after fetch_valid");
            check_eq(32'(fetch_data), 32'(model[addr]), "fetch_data hold");
        end
    endtask

    // Requests must be ignored while the load switch is on
    task automatic fetch_while_loading(input int addr);
        start_load();
        check_eq(32'(fetch_ready), 0, "fetch_ready while loading");
        fetch_req = 1'b1;
        fetch_addr = 6'(addr);
        @(negedge sysclk);
        fetch_req = 1'b0;
        repeat (10) begin
            check_eq(32'(fetch_valid), 0, "fetch_valid while loading");
            check_eq(32'(fetch_ready), 0, "fetch_ready while loading");
            @(negedge sysclk);
        end
        stop_load();
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge sysclk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        int errors_before;
        int bytes;
        int fetches;
        sysrst = 1'b0;
        rx = 1'b1;
        load_en = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        build_table();
        bytes = 0;
        fetches = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            bytes += 2 * t_nwords[i] + int'(t_bad[i]);
            fetches += t_nfetch[i] + ((t_kind[i] == K_BUSY) ? 1 : 0);
        end
        limit_cycles = 2 * (bytes * 10 * `BAUD_DIV + fetches * 20);

        repeat (3) @(negedge sysclk);
        sysrst = 1'b1;
        check_eq(32'(word_count), 0, "word_count after reset");
        check_eq(32'(fetch_valid), 0, "fetch_valid after reset");
        repeat (2) @(negedge sysclk);
        check_eq(32'(fetch_ready), 1, "fetch_ready after reset");

        for (int i = 0; i < N_TESTS; i++) begin
            errors_before = errors;
            if (t_kind[i] == K_LOAD) begin
                start_load();
                if (t_bad[i]) begin
                    send_byte(8'h96, 1'b0);
                end
                for (int k = 0; k < t_nwords[i]; k++) begin
                    send_word(t_image[i][k]);
                    model[k] = t_image[i][k];
                end
                wait_count(t_nwords[i]);
                stop_load();
            end else if (t_kind[i] == K_BUSY) begin
                fetch_while_loading(t_faddr[i][0]);
            end
            for (int k = 0; k < t_nfetch[i]; k++) begin
                do_fetch(t_faddr[i][k]);
            end
            if (errors != errors_before) begin
                failed_tests++;
            end
            $display("test %0d (%s): %s", i, t_name[i],
                     (errors == errors_before) ? "ok" : "errors");
        end

        $display("tests run %0d, tests failed %0d, errors %0d", N_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic sysclk
);
    // Free running, first rising edge at half a period
    initial begin
        sysclk = 1'b0;
        forever #(PERIOD_NS / 2.0) sysclk = ~sysclk;
    end

endmodule
